// File: verilog/mulshift_pkg.sv
// Multiply/shift lane package: data widths, opcode bit positions and opcode codes.
package mulshift_pkg;

  localparam int unsigned LANE_W    = 32;  // Lane data width.
  localparam int unsigned LANE_LOG2 = 5;   // Bits of a shift amount.

  typedef logic [LANE_W-1:0]     word_t;     // One lane data word.
  typedef logic [LANE_W:0]       wide_t;     // Word plus sign-extension bit.
  typedef logic [2*LANE_W+1:0]   product_t;  // Full 33x33 product.
  typedef logic [LANE_LOG2-1:0]  shamt_t;    // Shift amount.
  typedef logic [4:0]            mul_op_t;   // Opcode.

  // Opcode fields, one bit each.
  localparam int unsigned OP_DIR_BIT      = 0;  // Right shift / high half.
  localparam int unsigned OP_UNSIGNED_BIT = 1;  // Unsigned operation.
  localparam int unsigned OP_MUL_BIT      = 2;  // Multiply, not shift.
  localparam int unsigned OP_SAT_BIT      = 3;  // Saturating shift.
  localparam int unsigned OP_HALF_BIT     = 4;  // Half-word multiply.

  // Codes, laid out as {half, sat, mul, unsigned, dir}.
  localparam mul_op_t OP_ZERO     = 5'b00000;  // Forces a zero result.
  localparam mul_op_t OP_SLL      = 5'b00010;  // Logical left shift.
  localparam mul_op_t OP_SRL      = 5'b00011;  // Logical right shift.
  localparam mul_op_t OP_SRA      = 5'b00001;  // Arithmetic right shift.
  localparam mul_op_t OP_SLL_SATU = 5'b01010;  // Left shift, unsigned saturation.
  localparam mul_op_t OP_SLL_SAT  = 5'b01000;  // Left shift, signed saturation.
  localparam mul_op_t OP_MULLO    = 5'b00100;  // Signed, low word.
  localparam mul_op_t OP_MULHI    = 5'b00101;  // Signed, high word.
  localparam mul_op_t OP_MULLOU   = 5'b00110;  // Unsigned, low word.
  localparam mul_op_t OP_MULHIU   = 5'b00111;  // Unsigned, high word.
  localparam mul_op_t OP_LMUL     = 5'b10100;  // Signed lower halves.
  localparam mul_op_t OP_UMUL     = 5'b10101;  // Signed upper halves.
  localparam mul_op_t OP_LMULU    = 5'b10110;  // Unsigned lower halves.
  localparam mul_op_t OP_UMULU    = 5'b10111;  // Unsigned upper halves.

endpackage

// File: verilog/mul_operand_prep.sv
// Operand preparation: half-word pick, sign extension and 33-bit widening of both operands.
`timescale 1ns/1ns

module mul_operand_prep
  import mulshift_pkg::*;
#(
  parameter int WIDTH = 32
)
(
  input  word_t   opa,
  input  word_t   opb,
  input  mul_op_t op,
  output wide_t   mul_a,
  output wide_t   mul_b,
  output logic    a_negative
);

  localparam int HW = WIDTH / 2;  // Half-word width.

  logic  is_signed;  // Signed operation.
  logic  is_mul;     // Multiply opcode.
  logic  half;       // Half-word mode.
  logic  dir;        // Upper half in half mode.
  logic  half_sx;    // Sign-extend picked half.
  word_t prep_a;     // Operand A after half pick.
  word_t prep_b;     // Operand B after half pick.

  assign is_signed = ~op[OP_UNSIGNED_BIT];
  assign is_mul    = op[OP_MUL_BIT];
  assign half      = op[OP_HALF_BIT];
  assign dir       = op[OP_DIR_BIT];
  assign half_sx   = is_signed & is_mul;  // Only signed multiplies extend the sign.

  // Picks one half of a word and extends it to full width.
  function automatic word_t pick_half(input word_t w, input logic upper, input logic sx);
    word_t res;
    if (upper)
    begin
      res = {{HW{sx & w[WIDTH-1]}}, w[WIDTH-1:HW]};  // Upper half.
    end
    else
    begin
      res = {{HW{sx & w[HW-1]}}, w[HW-1:0]};  // Lower half.
    end
    return res;
  endfunction

  always_comb
  begin
    if (half)
    begin
      prep_a = pick_half(opa, dir, half_sx);
      prep_b = pick_half(opb, dir, half_sx);
    end
    else
    begin
      prep_a = opa;  // Full word passes unchanged.
      prep_b = opb;
    end
  end

  // 33rd bit is the sign for signed ops, zero for unsigned.
  assign mul_a = {is_signed & prep_a[WIDTH-1], prep_a};
  assign mul_b = {is_signed & prep_b[WIDTH-1], prep_b};

  assign a_negative = prep_a[WIDTH-1];  // Picks the signed saturation value.

endmodule

// File: verilog/shift_amount_decoder.sv
// Shift-amount decoder: power-of-two factor for shifts and the high/low half decision.
`timescale 1ns/1ns

module shift_amount_decoder
  import mulshift_pkg::*;
#(
  parameter int WIDTH     = 32,
  parameter int LOG2WIDTH = 5
)
(
  input  shamt_t  sa,
  input  mul_op_t op,
  output wide_t   shift_factor,
  output logic    sel_hi
);

  logic                 is_mul;   // Multiply opcode.
  logic                 dir;      // Right shift or high half.
  logic [LOG2WIDTH-1:0] left_sa;  // Equivalent left shift.

  assign is_mul = op[OP_MUL_BIT];
  assign dir    = op[OP_DIR_BIT];

  // Right shift by sa is a left shift by WIDTH-sa, read from the high half.
  // sa of zero wraps to zero here and is taken from the low half.
  assign left_sa = dir ? LOG2WIDTH'(WIDTH - int'(sa)) : sa;

  // One-hot 2**left_sa.
  assign shift_factor = {{WIDTH{1'b0}}, 1'b1} << left_sa;

  always_comb
  begin
    if (is_mul)
    begin
      sel_hi = dir;  // MULHI, UMUL and friends.
    end
    else
    begin
      sel_hi = dir & (|sa);  // Right shift by nonzero amount.
    end
  end

endmodule

// File: verilog/signed_mult_pipe.sv
// Registered signed 33x33 multiplier with clock enable and synchronous clear.
`timescale 1ns/1ns

module signed_mult_pipe
  import mulshift_pkg::*;
#(
  parameter int WIDTH = 32
)
(
  input  logic     clk,
  input  logic     resetn,
  input  logic     en,
  input  wide_t    mul_a,
  input  wide_t    mul_b,
  output product_t product
);

  localparam int MW = WIDTH + 1;  // Multiplier operand width.

  logic signed [MW-1:0]   a_s;     // Signed view of A.
  logic signed [MW-1:0]   b_s;     // Signed view of B.
  logic signed [2*MW-1:0] prod_s;  // Full signed product.

  assign a_s    = mul_a;
  assign b_s    = mul_b;
  assign prod_s = a_s * b_s;  // Both operands signed, so this is a signed multiply.

  always_ff @(posedge clk)
  begin
    if (!resetn)
    begin
      product <= '0;  // Clear on reset.
    end
    else if (en)
    begin
      product <= prod_s;  // Capture under enable.
    end
  end

endmodule

// File: verilog/result_select.sv
// Result selection: registers stage-one flags and picks zero, saturation, high or low half.
`timescale 1ns/1ns

module result_select
  import mulshift_pkg::*;
#(
  parameter int WIDTH = 32
)
(
  input  logic     clk,
  input  logic     resetn,
  input  logic     en,
  input  mul_op_t  op,
  input  logic     a_negative,
  input  logic     sel_hi,
  input  product_t product,
  output word_t    result
);

  logic  zero_q;      // Zero opcode seen.
  logic  sat_q;       // Saturating shift.
  word_t sat_val_q;   // Value to saturate to.
  logic  sel_hi_q;    // Take the high half.
  word_t sat_val_d;   // Next saturation value.
  word_t hi;          // Product bits 63:32.
  word_t lo;          // Product bits 31:0.

  // Top two product bits are never needed.
  assign hi = product[2*WIDTH-1:WIDTH];
  assign lo = product[WIDTH-1:0];

  always_comb
  begin
    if (op[OP_UNSIGNED_BIT])
    begin
      sat_val_d = '1;  // Unsigned max.
    end
    else if (a_negative)
    begin
      sat_val_d = {1'b1, {(WIDTH-1){1'b0}}};  // Most negative.
    end
    else
    begin
      sat_val_d = {1'b0, {(WIDTH-1){1'b1}}};  // Most positive.
    end
  end

  // Zero flag has no reset; first enabled op sets it.
  always_ff @(posedge clk)
  begin
    if (en)
    begin
      zero_q <= (op[3:0] == 4'b0000);
    end
  end

  always_ff @(posedge clk)
  begin
    if (!resetn)
    begin
      sat_q     <= 1'b0;
      sat_val_q <= '0;
      sel_hi_q  <= 1'b0;
    end
    else if (en)
    begin
      sat_q     <= op[OP_SAT_BIT];
      sat_val_q <= sat_val_d;
      sel_hi_q  <= sel_hi;
    end
  end

  // Zero wins, then overflow saturation, then half select.
  assign result = zero_q              ? '0 :
                  (sat_q && (|hi))    ? sat_val_q :
                  sel_hi_q            ? hi : lo;

endmodule

// File: verilog/vlane_mulshift.sv
// Vector lane multiply/shift unit: all operations on one registered 33x33 signed multiplier.
`timescale 1ns/1ns

module vlane_mulshift
  import mulshift_pkg::*;
#(
  parameter int WIDTH     = 32,
  parameter int LOG2WIDTH = 5
)
(
  input  logic    clk,
  input  logic    resetn,
  input  word_t   opa,
  input  word_t   opb,
  input  shamt_t  sa,
  input  mul_op_t op,
  input  logic    en,
  output word_t   result
);

  wide_t    mul_a;         // Widened operand A.
  wide_t    mul_b;         // Half-selected operand B.
  logic     a_negative;    // Sign of prepared A.
  wide_t    shift_factor;  // 2**shift for shift ops.
  logic     sel_hi;        // High half wanted.
  wide_t    mult_b;        // Multiplier B input.
  product_t product;       // Registered product.

  mul_operand_prep #(
    .WIDTH (WIDTH)
  ) u_prep (
    .opa        (opa),
    .opb        (opb),
    .op         (op),
    .mul_a      (mul_a),
    .mul_b      (mul_b),
    .a_negative (a_negative)
  );

  shift_amount_decoder #(
    .WIDTH     (WIDTH),
    .LOG2WIDTH (LOG2WIDTH)
  ) u_sa_dec (
    .sa           (sa),
    .op           (op),
    .shift_factor (shift_factor),
    .sel_hi       (sel_hi)
  );

  // Shifts multiply by the decoded power of two.
  assign mult_b = op[OP_MUL_BIT] ? mul_b : shift_factor;

  signed_mult_pipe #(
    .WIDTH (WIDTH)
  ) u_mult (
    .clk     (clk),
    .resetn  (resetn),
    .en      (en),
    .mul_a   (mul_a),
    .mul_b   (mult_b),
    .product (product)
  );

  result_select #(
    .WIDTH (WIDTH)
  ) u_sel (
    .clk        (clk),
    .resetn     (resetn),
    .en         (en),
    .op         (op),
    .a_negative (a_negative),
    .sel_hi     (sel_hi),
    .product    (product),
    .result     (result)
  );

endmodule

// File: testbench/mulshift_model.svh
// Reference model for the multiply/shift lane, built from the opcode rules.
`ifndef MULSHIFT_MODEL_SVH
`define MULSHIFT_MODEL_SVH

// Full word taken to 64 bits.
function automatic logic [63:0] widen_word(input word_t w, input logic sgn);
  return sgn ? {{32{w[31]}}, w} : {32'b0, w};
endfunction

// Chosen 16-bit half taken to 64 bits.
function automatic logic [63:0] widen_half(input word_t w, input logic upper, input logic sgn);
  logic [15:0] h;
  h = upper ? w[31:16] : w[15:0];
  return sgn ? {{48{h[15]}}, h} : {48'b0, h};
endfunction

function automatic word_t expected_result(input word_t a, input word_t b,
                                          input shamt_t s, input mul_op_t o);
  logic               sgn;   // Signed operation.
  logic               dir;   // Right shift or high half.
  logic [63:0]        full;  // Exact 64-bit product.
  logic signed [31:0] a_s;   // Signed view for SRA.
  sgn = !o[OP_UNSIGNED_BIT];
  dir = o[OP_DIR_BIT];
  if (o[3:0] == 4'b0000)
  begin
    return '0;  // Zero opcode.
  end
  if (o[OP_MUL_BIT])
  begin
    if (o[OP_HALF_BIT])
    begin
      full = widen_half(a, dir, sgn) * widen_half(b, dir, sgn);
    end
    else
    begin
      full = widen_word(a, sgn) * widen_word(b, sgn);
    end
    return dir ? full[63:32] : full[31:0];  // Direction bit picks the high word.
  end
  if (dir)
  begin
    if (!sgn)
    begin
      return a >> s;  // SRL.
    end
    a_s = a;
    a_s = a_s >>> s;  // SRA.
    return a_s;
  end
  full = widen_word(a, sgn) << s;
  if (o[OP_SAT_BIT] && (full[63:32] != 32'h0))
  begin
    if (!sgn)
    begin
      return 32'hffff_ffff;  // Unsigned ceiling.
    end
    return a[31] ? 32'h8000_0000 : 32'h7fff_ffff;  // Sign of opa picks min or max.
  end
  return full[31:0];  // Plain left shift.
endfunction

`endif

// File: testbench/tb_vlane_mulshift.sv
// Testbench for the vector lane multiply/shift unit, checked against a reference model.
`timescale 1ns/1ns

module tb_vlane_mulshift
  import mulshift_pkg::*;
();

  localparam int WIDTH        = 32;
  localparam int LOG2WIDTH    = 5;
  localparam int RESET_CYCLES = 3;
  localparam int NUM_TESTS    = 6;
  localparam int NB           = 6;   // Boundary operands.
  localparam int NRAND        = 24;  // Random ops per opcode group.
  localparam int HOLD_CYCLES  = 5;   // Idle cycles per hold phase.
  localparam int NB2B         = 40;  // Back-to-back ops.
  localparam int MUL_OPS      = 4 * (NB * NB + NRAND);
  localparam int SHIFT_OPS    = 3 * NB + NRAND;  // Per shift opcode.
  localparam int ZERO_OPS     = 6;
  localparam int TOTAL_OPS    = 2 * MUL_OPS + 5 * SHIFT_OPS + ZERO_OPS + NB2B;
  localparam int CYCLE_LIMIT  = 2 * TOTAL_OPS + RESET_CYCLES;

  logic    clk;
  logic    resetn;
  word_t   opa;
  word_t   opb;
  shamt_t  sa;
  mul_op_t op;
  logic    en;
  word_t   result;

  int      seed;
  int      cycle_count;
  int      issued_test;  // Test tag riding with the inputs.
  logic    armed;        // An enabled op has been captured.
  word_t   exp_q;        // Expected result of last captured op.
  int      exp_test;     // Its test tag.
  int      checks [NUM_TESTS];
  int      fails [NUM_TESTS];
  string   test_names [NUM_TESTS];
  word_t   bounds [NB];
  mul_op_t all_ops [14];

  `include "mulshift_model.svh"

  vlane_mulshift #(
    .WIDTH     (WIDTH),
    .LOG2WIDTH (LOG2WIDTH)
  ) UUT (
    .clk    (clk),
    .resetn (resetn),
    .opa    (opa),
    .opb    (opb),
    .sa     (sa),
    .op     (op),
    .en     (en),
    .result (result)
  );

  always #20 clk = ~clk;  // 40 ns period.

  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT)
    begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  // Expected value follows what the DUT captures on the same edge.
  always @(posedge clk)
  begin
    if (!resetn)
    begin
      armed <= 1'b0;
    end
    else if (en)
    begin
      armed    <= 1'b1;
      exp_q    <= expected_result(opa, opb, sa, op);
      exp_test <= issued_test;
    end
  end

  // Result is stable half a cycle after the edge.
  always @(negedge clk)
  begin
    if (armed)
    begin
      checks[exp_test] = checks[exp_test] + 1;
      check_result: assert (result === exp_q)
      else
      begin
        $display("error %s: expected %h actual %h", test_names[exp_test], exp_q, result);
        fails[exp_test] = fails[exp_test] + 1;
      end
    end
  end

  task automatic issue(input mul_op_t o, input word_t a, input word_t b,
                       input shamt_t s, input int t);
    @(posedge clk);
    op          <= o;
    opa         <= a;
    opb         <= b;
    sa          <= s;
    en          <= 1'b1;
    issued_test <= t;
  endtask

  // Inputs wander while en is low.
  task automatic hold_idle(input int n);
    repeat (n)
    begin
      @(posedge clk);
      en  <= 1'b0;
      opa <= $random(seed);
      opb <= $random(seed);
      sa  <= shamt_t'($random(seed));
      op  <= all_ops[($random(seed) & 32'h7fff_ffff) % 14];
    end
  endtask

  // Random word of random magnitude.
  function automatic word_t random_word();
    word_t w;
    w = $random(seed);
    return w >> ($random(seed) & 31);
  endfunction

  // Lets the last op of a test get checked, then reports it.
  task automatic finish_test(input int t);
    @(posedge clk);
    en <= 1'b0;
    @(posedge clk);
    $display("%-12s checks %4d errors %0d", test_names[t], checks[t], fails[t]);
  endtask

  // Four opcodes of a family differ only in the unsigned and direction bits.
  task automatic mul_test(input mul_op_t base, input int t);
    for (int k = 0; k < 4; k++)
    begin
      for (int i = 0; i < NB; i++)
      begin
        for (int j = 0; j < NB; j++)
        begin
          issue(base | mul_op_t'(k), bounds[i], bounds[j], shamt_t'($random(seed)), t);
        end
      end
      repeat (NRAND)
      begin
        issue(base | mul_op_t'(k), $random(seed), $random(seed), shamt_t'($random(seed)), t);
      end
    end
  endtask

  task automatic shift_test(input mul_op_t o, input int t);
    for (int i = 0; i < NB; i++)
    begin
      issue(o, bounds[i], $random(seed), 5'd0, t);
      issue(o, bounds[i], $random(seed), 5'd1, t);
      issue(o, bounds[i], $random(seed), 5'd31, t);
    end
    repeat (NRAND)
    begin
      issue(o, random_word(), $random(seed), shamt_t'($random(seed)), t);
    end
  endtask

  initial
  begin
    int total_checks;
    int total_fails;
    seed        = 32'h5d2d;
    clk         = 1'b0;
    resetn      = 1'b0;
    en          = 1'b0;
    opa         = '0;
    opb         = '0;
    sa          = '0;
    op          = OP_ZERO;
    cycle_count = 0;
    issued_test = 0;
    armed       = 1'b0;
    exp_q       = '0;
    exp_test    = 0;
    test_names  = '{"full_mul", "half_mul", "shift", "sat_shift", "zero_hold", "back_to_back"};
    bounds      = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff,
                    32'h7fff_ffff, 32'h8000_0000, 32'h0001_8000};
    all_ops     = '{OP_ZERO, OP_SLL, OP_SRL, OP_SRA, OP_SLL_SATU, OP_SLL_SAT, OP_MULLO,
                    OP_MULHI, OP_MULLOU, OP_MULHIU, OP_LMUL, OP_UMUL, OP_LMULU, OP_UMULU};
    repeat (RESET_CYCLES) @(posedge clk);
    resetn <= 1'b1;
    mul_test(OP_MULLO, 0);
    finish_test(0);
    mul_test(OP_LMUL, 1);
    finish_test(1);
    shift_test(OP_SLL, 2);
    shift_test(OP_SRL, 2);
    shift_test(OP_SRA, 2);
    finish_test(2);
    shift_test(OP_SLL_SATU, 3);
    shift_test(OP_SLL_SAT, 3);
    finish_test(3);
    repeat (4) issue(OP_ZERO, $random(seed), $random(seed), shamt_t'($random(seed)), 4);
    issue(OP_MULLO, $random(seed), $random(seed), shamt_t'($random(seed)), 4);
    hold_idle(HOLD_CYCLES);  // Product result must hold.
    issue(OP_ZERO, $random(seed), $random(seed), shamt_t'($random(seed)), 4);
    hold_idle(HOLD_CYCLES);  // Zero must hold.
    finish_test(4);
    repeat (NB2B)
    begin
      issue(all_ops[($random(seed) & 32'h7fff_ffff) % 14], random_word(), $random(seed),
            shamt_t'($random(seed)), 5);
    end
    finish_test(5);
    total_checks = 0;
    total_fails  = 0;
    for (int t = 0; t < NUM_TESTS; t++)
    begin
      total_checks += checks[t];
      total_fails  += fails[t];
    end
    $display("tests %0d, checks %0d, errors %0d", NUM_TESTS, total_checks, total_fails);
    if (total_fails == 0 && total_checks > 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

// File: tb.f
+incdir+testbench
verilog/mulshift_pkg.sv
verilog/mul_operand_prep.sv
verilog/shift_amount_decoder.sv
verilog/signed_mult_pipe.sv
verilog/result_select.sv
verilog/vlane_mulshift.sv
testbench/tb_vlane_mulshift.sv

// File: Bender.yml
package:
  name: vlane_mulshift

sources:
  - files:
      - verilog/mulshift_pkg.sv
      - verilog/mul_operand_prep.sv
      - verilog/shift_amount_decoder.sv
      - verilog/signed_mult_pipe.sv
      - verilog/result_select.sv
      - verilog/vlane_mulshift.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_vlane_mulshift.sv
